// File: cmd_decoder.sv
`timescale 1ns/1ps
`include "stepper_settings.svh"

module cmd_decoder (
  input  logic                         CLK,
  input  logic                         resetn,
  input  stepper_pkg::word_t           word_data,
  input  logic                         word_valid,
  output logic                         word_ready,
  output stepper_pkg::word_t           reply_data,
  input  logic                         buf_full,
  input  stepper_pkg::position_array_t positions,
  output logic [7:0]                   clock_divisor,
  output stepper_pkg::axis_mask_t      enable_mask,
  output stepper_pkg::axis_mask_t      buf_dir,
  output stepper_pkg::duration_t       buf_duration,
  output stepper_pkg::rate_array_t     buf_rate,
  output stepper_pkg::rate_array_t     buf_rate_delta,
  output logic                         buf_wr_duration,
  output stepper_pkg::axis_mask_t      buf_wr_rate,
  output stepper_pkg::axis_mask_t      buf_wr_delta,
  output logic                         buf_commit
);
  import stepper_pkg::*;

  // Duration word is 1, then rate and delta pairs
  localparam int LAST_WORD = 2 * `NUM_AXES + 1;

  logic [7:0] msg_header;
  logic [7:0] word_count;
  axis_mask_t dir_r;                   // Dir mask until the duration word
  position_t  snapshot [`NUM_AXES];
  logic       in_move;
  logic       accept;
  word_t      version_word;

  assign in_move = (msg_header == CMD_COORDINATED_STEP);

  // Hold off the duration word while the write slot is still queued
  assign word_ready = !(in_move && (word_count == 8'd1) && buf_full);
  assign accept     = word_valid && word_ready;

  assign version_word = {32'd0, `VERSION_DEVEL, `VERSION_MAJOR,
                         `VERSION_MINOR, `VERSION_PATCH};

  assign buf_dir      = dir_r;
  assign buf_duration = word_data[`MOVE_DURATION_BITS-1:0];

  always_comb begin
    buf_wr_duration = accept && in_move && (word_count == 8'd1);
    buf_commit      = accept && in_move && (word_count == 8'(LAST_WORD));
    for (int n = 0; n < `NUM_AXES; n++) begin
      buf_rate[n]       = word_data;
      buf_rate_delta[n] = word_data;
      buf_wr_rate[n]    = accept && in_move && (word_count == 8'(2 * n + 2));
      buf_wr_delta[n]   = accept && in_move && (word_count == 8'(2 * n + 3));
    end
  end

  // Positions frozen at the move header, read back during the move
  always_ff @(posedge CLK) begin
    if (accept && !in_move && (word_data[63:56] == CMD_COORDINATED_STEP)) begin
      for (int n = 0; n < `NUM_AXES; n++) begin
        snapshot[n] <= positions[n];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      msg_header    <= 8'd0;
      word_count    <= 8'd0;
      dir_r         <= '0;
      enable_mask   <= '0;
      clock_divisor <= `DEFAULT_CLOCK_DIVISOR;
      reply_data    <= '0;
    end else if (accept) begin
      reply_data <= '0;  // Default reply
      if (!in_move) begin
        case (word_data[63:56])
          CMD_COORDINATED_STEP: begin
            msg_header <= word_data[63:56];
            word_count <= 8'd1;
            dir_r      <= word_data[`NUM_AXES-1:0];
          end
          CMD_MOTOR_ENABLE: begin
            enable_mask <= word_data[`NUM_AXES-1:0];
          end
          CMD_CLK_DIVISOR: begin
            // Zero would stall the tick divider
            clock_divisor <= (word_data[7:0] == 8'd0) ? 8'd1 : word_data[7:0];
          end
          CMD_API_VERSION: begin
            reply_data <= version_word;
          end
          default: ;  // Unknown header, reply stays zero
        endcase
      end else begin
        word_count <= word_count + 8'd1;
        if (word_count == 8'd1) begin
          reply_data <= 64'(snapshot[0]);  // Sign extended
        end
        // Delta word of axis n returns axis n+1
        for (int n = 0; n < `NUM_AXES - 1; n++) begin
          if (word_count == 8'(2 * n + 3)) begin
            reply_data <= 64'(snapshot[n + 1]);
          end
        end
        if (buf_commit) begin
          msg_header <= 8'd0;
          word_count <= 8'd0;
        end
      end
    end
  end

  // Back-pressure must keep a commit off a queued slot
  a_no_commit_when_full: assert property (
    @(posedge CLK) disable iff (resetn) buf_commit |-> !buf_full
  );

endmodule

// File: dda_axis.sv
`timescale 1ns/1ps

module dda_axis (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               dda_tick,
  input  logic               load_move,
  input  logic               executing,
  input  stepper_pkg::rate_t rate,
  input  stepper_pkg::rate_t rate_delta,
  output logic               step_req
);
  import stepper_pkg::*;

  logic [63:0] acc;
  rate_t       cur_rate;
  rate_t       cur_delta;  // Ramp of the running move
  logic [64:0] acc_sum;
  logic        advance;

  assign advance  = dda_tick && executing;
  assign acc_sum  = {1'b0, acc} + {1'b0, cur_rate};
  assign step_req = advance && acc_sum[64];  // Carry out of bit 63

  always_ff @(posedge CLK) begin
    if (resetn) begin
      acc       <= '0;
      cur_rate  <= '0;
      cur_delta <= '0;
    end else if (load_move) begin
      acc       <= '0;
      cur_rate  <= rate;
      cur_delta <= rate_delta;  // Head slot moves on after the load
    end else if (advance) begin
      acc      <= acc_sum[63:0];
      cur_rate <= cur_rate + cur_delta;  // Ramp for the next tick
    end
  end

endmodule

// File: dda_sequencer.sv
`timescale 1ns/1ps

module dda_sequencer (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic [7:0]             clock_divisor,
  input  logic                   move_valid,
  input  stepper_pkg::duration_t move_duration,
  output logic                   move_ready,
  output logic                   dda_tick,
  output logic                   load_move,
  output logic                   executing,
  output logic                   move_done
);
  import stepper_pkg::*;

  logic [7:0] div_cnt;
  duration_t  ticks_left;
  logic       running;
  logic       done_r;

  // Free-running tick, one cycle in clock_divisor
  assign dda_tick = (div_cnt == 8'd0);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt <= 8'd0;
    end else if (div_cnt >= clock_divisor - 8'd1) begin
      div_cnt <= 8'd0;
    end else begin
      div_cnt <= div_cnt + 8'd1;
    end
  end

  // Gap cycle after done keeps move_done a single pulse
  assign move_ready = !running && !done_r && move_valid;
  assign load_move  = move_ready;
  assign executing  = running;
  assign move_done  = done_r;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      running    <= 1'b0;
      ticks_left <= '0;
      done_r     <= 1'b0;
    end else begin
      done_r <= 1'b0;
      if (load_move) begin
        ticks_left <= move_duration;
        running    <= (move_duration != '0);
        done_r     <= (move_duration == '0);  // Empty move ends at once
      end else if (running && dda_tick) begin
        ticks_left <= ticks_left - 1'b1;
        if (ticks_left == duration_t'(1)) begin
          running <= 1'b0;
          done_r  <= 1'b1;
        end
      end
    end
  end

  a_done_one_cycle: assert property (
    @(posedge CLK) disable iff (resetn) move_done |=> !move_done
  );

endmodule

// File: move_buffer.sv
`timescale 1ns/1ps
`include "stepper_settings.svh"

module move_buffer (
  input  logic                     CLK,
  input  logic                     resetn,
  input  stepper_pkg::axis_mask_t  buf_dir,
  input  stepper_pkg::duration_t   buf_duration,
  input  stepper_pkg::rate_array_t buf_rate,
  input  stepper_pkg::rate_array_t buf_rate_delta,
  input  logic                     buf_wr_duration,
  input  stepper_pkg::axis_mask_t  buf_wr_rate,
  input  stepper_pkg::axis_mask_t  buf_wr_delta,
  input  logic                     buf_commit,
  input  logic                     move_ready,
  output logic                     buf_full,
  output logic                     buffer_dtr,
  output logic                     move_valid,
  output stepper_pkg::axis_mask_t  move_dir,
  output stepper_pkg::duration_t   move_duration,
  output stepper_pkg::rate_array_t move_rate,
  output stepper_pkg::rate_array_t move_rate_delta
);
  import stepper_pkg::*;

  localparam int DEPTH = `MOVE_BUFFER_DEPTH;
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  axis_mask_t       slot_dir      [DEPTH];
  duration_t        slot_duration [DEPTH];
  rate_array_t      slot_rate     [DEPTH];
  rate_array_t      slot_delta    [DEPTH];
  logic [DEPTH-1:0] slot_full;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (idx == IDX_W'(DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_ff @(posedge CLK) begin
    if (buf_wr_duration) begin
      slot_dir[wr_idx]      <= buf_dir;
      slot_duration[wr_idx] <= buf_duration;
    end
    for (int n = 0; n < `NUM_AXES; n++) begin
      if (buf_wr_rate[n])  slot_rate[wr_idx][n]  <= buf_rate[n];
      if (buf_wr_delta[n]) slot_delta[wr_idx][n] <= buf_rate_delta[n];
    end
  end

  // Commit and take never hit the same slot
  always_ff @(posedge CLK) begin
    if (resetn) begin
      slot_full <= '0;
      wr_idx    <= '0;
      rd_idx    <= '0;
    end else begin
      if (buf_commit) begin
        slot_full[wr_idx] <= 1'b1;
        wr_idx            <= next_idx(wr_idx);
      end
      if (move_ready) begin
        slot_full[rd_idx] <= 1'b0;
        rd_idx            <= next_idx(rd_idx);
      end
    end
  end

  assign buf_full        = slot_full[wr_idx];
  assign buffer_dtr      = ~&slot_full;   // Some slot free
  assign move_valid      = slot_full[rd_idx];
  assign move_dir        = slot_dir[rd_idx];
  assign move_duration   = slot_duration[rd_idx];
  assign move_rate       = slot_rate[rd_idx];
  assign move_rate_delta = slot_delta[rd_idx];

  a_ready_needs_valid: assert property (
    @(posedge CLK) disable iff (resetn) move_ready |-> move_valid
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_stepper_ctrl -f verilog.f \
  || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_stepper_ctrl 2>&1)" || true
echo "$sim_out"

grep -qx '>>> PASS' <<< "$sim_out" && exit 0 || exit 1

// File: step_output.sv
`timescale 1ns/1ps
`include "stepper_settings.svh"

module step_output (
  input  logic                         CLK,
  input  logic                         resetn,
  input  stepper_pkg::axis_mask_t      step_req,
  input  stepper_pkg::axis_mask_t      move_dir,
  input  logic                         load_move,
  input  stepper_pkg::axis_mask_t      enable_mask,
  output stepper_pkg::axis_mask_t      step,
  output stepper_pkg::axis_mask_t      dir,
  output stepper_pkg::axis_mask_t      enable,
  output stepper_pkg::position_array_t positions
);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step   <= '0;
      dir    <= '0;
      enable <= '0;
      for (int n = 0; n < `NUM_AXES; n++) begin
        positions[n] <= '0;
      end
    end else begin
      step   <= step_req;     // One cycle pulse per request
      enable <= enable_mask;
      if (load_move) begin
        dir <= move_dir;      // Held for the whole move
      end
      // Dir is already latched when the first request comes
      for (int n = 0; n < `NUM_AXES; n++) begin
        if (step_req[n]) begin
          positions[n] <= dir[n] ? positions[n] + 32'sd1 : positions[n] - 32'sd1;
        end
      end
    end
  end

endmodule

// File: stepper_ctrl_top.sv
`timescale 1ns/1ps
`include "stepper_settings.svh"

module stepper_ctrl_top (
  input  logic                    CLK,
  input  logic                    resetn,
  input  stepper_pkg::word_t      word_data,
  input  logic                    word_valid,
  output logic                    word_ready,
  output stepper_pkg::word_t      reply_data,
  output stepper_pkg::axis_mask_t step,
  output stepper_pkg::axis_mask_t dir,
  output stepper_pkg::axis_mask_t enable,
  output logic                    move_done,
  output logic                    buffer_dtr
);
  import stepper_pkg::*;

  logic [7:0]      clock_divisor;
  axis_mask_t      enable_mask;
  position_array_t positions;

  // Decoder into the write slot
  axis_mask_t  buf_dir;
  duration_t   buf_duration;
  rate_array_t buf_rate;
  rate_array_t buf_rate_delta;
  logic        buf_wr_duration;
  axis_mask_t  buf_wr_rate;
  axis_mask_t  buf_wr_delta;
  logic        buf_commit;
  logic        buf_full;

  // Head of the buffer
  logic        move_valid;
  logic        move_ready;
  axis_mask_t  move_dir;
  duration_t   move_duration;
  rate_array_t move_rate;
  rate_array_t move_rate_delta;

  logic        dda_tick;
  logic        load_move;
  logic        executing;
  axis_mask_t  step_req;

  cmd_decoder u_decoder (
    .CLK, .resetn, .word_data, .word_valid, .word_ready, .reply_data,
    .buf_full, .positions, .clock_divisor, .enable_mask,
    .buf_dir, .buf_duration, .buf_rate, .buf_rate_delta,
    .buf_wr_duration, .buf_wr_rate, .buf_wr_delta, .buf_commit
  );

  move_buffer u_buffer (
    .CLK, .resetn, .buf_dir, .buf_duration, .buf_rate, .buf_rate_delta,
    .buf_wr_duration, .buf_wr_rate, .buf_wr_delta, .buf_commit, .move_ready,
    .buf_full, .buffer_dtr, .move_valid, .move_dir, .move_duration,
    .move_rate, .move_rate_delta
  );

  dda_sequencer u_sequencer (
    .CLK, .resetn, .clock_divisor, .move_valid, .move_duration,
    .move_ready, .dda_tick, .load_move, .executing, .move_done
  );

  for (genvar n = 0; n < `NUM_AXES; n++) begin : g_axis
    dda_axis u_axis (
      .CLK, .resetn, .dda_tick, .load_move, .executing,
      .rate       (move_rate[n]),
      .rate_delta (move_rate_delta[n]),
      .step_req   (step_req[n])
    );
  end

  step_output u_output (
    .CLK, .resetn, .step_req, .move_dir, .load_move, .enable_mask,
    .step, .dir, .enable, .positions
  );

endmodule

// File: stepper_pkg.sv
`include "stepper_settings.svh"

package stepper_pkg;

  // One host word
  typedef logic [63:0] word_t;

  // Command code, top byte of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_API_VERSION      = 8'hfe
  } cmd_t;

  // One bit per axis
  typedef logic [`NUM_AXES-1:0] axis_mask_t;

  // Rate and rate delta share this type
  typedef logic signed [63:0] rate_t;

  typedef logic [`MOVE_DURATION_BITS-1:0] duration_t;

  // Signed step count
  typedef logic signed [31:0] position_t;

  typedef rate_t     rate_array_t     [`NUM_AXES];
  typedef position_t position_array_t [`NUM_AXES];

endpackage

// File: stepper_settings.svh
`ifndef STEPPER_SETTINGS_SVH
`define STEPPER_SETTINGS_SVH

// Motor axes driven by the controller
`define NUM_AXES 2

// Width of a move duration in DDA ticks
`define MOVE_DURATION_BITS 32

// Queued moves
`define MOVE_BUFFER_DEPTH 2

// Clock cycles per DDA tick out of reset
`define DEFAULT_CLOCK_DIVISOR 8'd40

// API version reply bytes
`define VERSION_MAJOR 8'd1
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd0
`define VERSION_DEVEL 8'd0

`endif

// File: tb_stepper_ctrl.sv
`timescale 1ns/1ps
`include "stepper_settings.svh"

module tb_stepper_ctrl;
  import stepper_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int MAX_ENTRIES = 48;
  localparam int MAX_TICKS   = 64;  // Longest move in the table
  localparam int DIV_BOUND   = int'(`DEFAULT_CLOCK_DIVISOR);
  localparam int SYNC_NONE    = 0;
  localparam int SYNC_OUTPUTS = 1;  // Enable and dir after the word
  localparam int SYNC_MOVES   = 2;  // All moves so far finished
  localparam rate_t R58 = 64'h0400_0000_0000_0000;
  localparam rate_t R60 = 64'h1000_0000_0000_0000;
  localparam rate_t R61 = 64'h2000_0000_0000_0000;
  localparam rate_t R62 = 64'h4000_0000_0000_0000;
  localparam rate_t R63 = 64'h8000_0000_0000_0000;

  logic       CLK;
  logic       resetn;
  word_t      word_data;
  logic       word_valid;
  logic       word_ready;
  word_t      reply_data;
  axis_mask_t step;
  axis_mask_t dir;
  axis_mask_t enable;
  logic       move_done;
  logic       buffer_dtr;

  // Stimulus table, plus the model state expected at each entry
  string      names     [MAX_ENTRIES];
  word_t      words     [MAX_ENTRIES];
  word_t      replies   [MAX_ENTRIES];
  logic       checked   [MAX_ENTRIES];
  int         syncs     [MAX_ENTRIES];
  int         done_at   [MAX_ENTRIES];
  axis_mask_t dir_at    [MAX_ENTRIES];
  axis_mask_t enable_at [MAX_ENTRIES];
  position_t  pos_at    [MAX_ENTRIES][`NUM_AXES];
  int         n_entries;
  logic       table_ready;

  position_array_t exp_pos;
  axis_mask_t      exp_dir;
  axis_mask_t      exp_enable;
  int              exp_done;

  int          up_cnt   [`NUM_AXES];
  int          down_cnt [`NUM_AXES];
  int          done_count;
  int          stall_cycles;
  logic        seen_full;
  logic [31:0] lfsr;

  stepper_ctrl_top i_dut (
    .CLK, .resetn, .word_data, .word_valid, .word_ready, .reply_data,
    .step, .dir, .enable, .move_done, .buffer_dtr
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Step pulses counted per axis and direction
  always @(negedge CLK) begin
    if (!resetn) begin
      for (int n = 0; n < `NUM_AXES; n++) begin
        if (step[n] && dir[n]) up_cnt[n]++;
        if (step[n] && !dir[n]) down_cnt[n]++;
      end
      if (move_done) done_count++;
      if (!buffer_dtr) seen_full = 1'b1;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
      else report_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Steps of one axis as floor(sum of rates / 2^64) over a linear ramp
  function automatic int unsigned dda_steps(input logic [31:0] ticks, input logic [63:0] rate,
                                            input logic [63:0] delta);
    logic [127:0] total;
    total = 128'(ticks) * 128'(rate)
          + 128'(delta) * ((128'(ticks) * (128'(ticks) - 128'd1)) >> 1);
    return total[95:64];
  endfunction

  task automatic add_entry(input string name, input word_t w, input word_t reply,
                           input logic chk, input int sync);
    names[n_entries]     = name;
    words[n_entries]     = w;
    replies[n_entries]   = reply;
    checked[n_entries]   = chk;
    syncs[n_entries]     = sync;
    done_at[n_entries]   = exp_done;
    dir_at[n_entries]    = exp_dir;
    enable_at[n_entries] = exp_enable;
    for (int n = 0; n < `NUM_AXES; n++) pos_at[n_entries][n] = exp_pos[n];
    n_entries++;
  endtask

  // Six words of a move; snapshot replies use positions before the move
  task automatic add_move(input string name, input axis_mask_t mdir, input duration_t dur,
                          input rate_array_t rates, input rate_array_t deltas,
                          input logic snap_chk, input int sync);
    word_t       snap [`NUM_AXES];
    int unsigned s;
    for (int n = 0; n < `NUM_AXES; n++) snap[n] = 64'(exp_pos[n]);
    for (int n = 0; n < `NUM_AXES; n++) begin
      s = dda_steps(dur, rates[n], deltas[n]);
      exp_pos[n] = mdir[n] ? exp_pos[n] + $signed(s) : exp_pos[n] - $signed(s);
    end
    exp_done++;
    exp_dir = mdir;
    add_entry({name, " header"}, {8'h01, 56'(mdir)}, '0, 1'b1, SYNC_NONE);
    add_entry({name, " duration"}, 64'(dur), snap[0], snap_chk, SYNC_NONE);
    for (int n = 0; n < `NUM_AXES; n++) begin
      add_entry($sformatf("%s rate %0d", name, n), rates[n], '0, 1'b1, SYNC_NONE);
      if (n < `NUM_AXES - 1)
        add_entry($sformatf("%s delta %0d", name, n), deltas[n], snap[n + 1], snap_chk,
                  SYNC_NONE);
      else
        add_entry($sformatf("%s delta %0d", name, n), deltas[n], '0, 1'b1, sync);
    end
  endtask

  task automatic send_word(input word_t w);
    @(posedge CLK);
    word_data  <= w;
    word_valid <= 1'b1;
    @(negedge CLK);
    while (!word_ready) begin
      stall_cycles++;
      @(negedge CLK);
    end
    @(posedge CLK);  // Accepted here
    word_valid <= 1'b0;
    @(negedge CLK);
  endtask

  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
    repeat (gap) @(posedge CLK);
  endtask

  task automatic check_outputs(input int i);
    check_value({names[i], " enable"}, 64'(enable_at[i]), 64'(enable));
    check_value({names[i], " dir"}, 64'(dir_at[i]), 64'(dir));
  endtask

  task automatic wait_moves(input int i);
    while (done_count < done_at[i]) @(posedge CLK);
    @(negedge CLK);
    check_value({names[i], " move_done count"}, 64'(done_at[i]), 64'(done_count));
    for (int n = 0; n < `NUM_AXES; n++)
      check_value($sformatf("%s axis %0d position", names[i], n),
                  64'(pos_at[i][n]), 64'(up_cnt[n] - down_cnt[n]));
    check_outputs(i);
  endtask

  initial begin
    resetn       = 1'b1;
    word_data    = '0;
    word_valid   = 1'b0;
    table_ready  = 1'b0;
    seen_full    = 1'b0;
    stall_cycles = 0;
    done_count   = 0;
    lfsr         = 32'hd8da5c1d;
    exp_dir      = '0;
    exp_enable   = '0;
    exp_done     = 0;
    for (int n = 0; n < `NUM_AXES; n++) exp_pos[n] = '0;

    // Patch in the low byte, devel in bits 31:24
    add_entry("api version", {8'hfe, 56'd0},
              (64'(`VERSION_DEVEL) << 24) | (64'(`VERSION_MAJOR) << 16) |
              (64'(`VERSION_MINOR) << 8) | 64'(`VERSION_PATCH),
              1'b1, SYNC_NONE);
    add_entry("unknown header", {8'h55, 56'h3}, '0, 1'b1, SYNC_OUTPUTS);
    exp_enable = 2'b11;
    add_entry("motor enable", {8'h0a, 56'h3}, '0, 1'b1, SYNC_OUTPUTS);
    add_entry("clock divisor", {8'h20, 56'h2}, '0, 1'b1, SYNC_NONE);
    add_move("single move", 2'b11, 8, '{R62, R63}, '{64'sd0, 64'sd0}, 1'b1, SYNC_MOVES);
    // Long move keeps the sequencer busy so the queue fills up
    add_move("reverse move", 2'b10, 64, '{R60, R61}, '{64'sd0, 64'sd0}, 1'b1, SYNC_NONE);
    // Ramp on axis 0 while the next move waits in the other slot
    add_move("queued move 1", 2'b01, 16, '{R62, R61}, '{R58, 64'sd0}, 1'b0, SYNC_NONE);
    add_move("queued move 2", 2'b00, 12, '{R63, R62}, '{64'sd0, 64'sd0}, 1'b0, SYNC_NONE);
    add_move("queued move 3", 2'b11, 10, '{R63, R63}, '{64'sd0, 64'sd0}, 1'b0, SYNC_MOVES);
    add_move("final snapshot", 2'b00, 0, '{64'sd0, 64'sd0}, '{64'sd0, 64'sd0}, 1'b1,
             SYNC_MOVES);
    table_ready = 1'b1;

    repeat (3) @(posedge CLK);
    resetn <= 1'b0;
    @(negedge CLK);
    check_value("reset enable", '0, 64'(enable));
    check_value("reset step", '0, 64'(step));
    check_value("reset dir", '0, 64'(dir));
    check_value("reset move_done", '0, 64'(move_done));
    check_value("reset buffer_dtr", 64'd1, 64'(buffer_dtr));
    check_value("reset reply_data", '0, reply_data);
    check_value("reset word_ready", 64'd1, 64'(word_ready));

    for (int i = 0; i < n_entries; i++) begin
      send_word(words[i]);
      if (checked[i]) check_value(names[i], replies[i], reply_data);
      if (syncs[i] == SYNC_OUTPUTS) begin
        @(negedge CLK);  // Enable lags acceptance by two cycles
        check_outputs(i);
      end else if (syncs[i] == SYNC_MOVES) begin
        wait_moves(i);
      end
      idle_gap();
    end

    assert (seen_full) else report_failure("buffer_dtr never fell with both slots full");
    assert (stall_cycles > 0) else report_failure("word_ready never stalled on a full buffer");
    $display(">>> PASS");
    $finish;
  end

  // Bound grows with the table, the move length and the slowest tick rate
  initial begin
    wait (table_ready);
    #(n_entries * MAX_TICKS * DIV_BOUND * CLK_PERIOD);
    report_failure("timeout, the DUT stopped accepting words or finishing moves");
  end

endmodule

// File: verilog.f
+incdir+.
stepper_pkg.sv
cmd_decoder.sv
move_buffer.sv
dda_sequencer.sv
dda_axis.sv
step_output.sv
stepper_ctrl_top.sv
tb_stepper_ctrl.sv
